// File: cmpFrontEnd.sv
`timescale 1ns/100ps
`default_nettype none

module cmpFrontEnd #(
    parameter int countWidth = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmp,
    input  tempSensPkg::phase_t   phase,
    input  logic                  ptatPolarity,
    input  logic                  chopPhase,
    output logic                  cmpSync,
    output logic                  cmpP1,
    output logic                  cmpP2,
    output logic [countWidth-1:0] tmpCount1,
    output logic [countWidth-1:0] tmpCount2
);

    logic cmpMeta;
    logic cmpPrev;
    logic [1:0] holdoff;
    logic tsChop;
    logic inTempSens;
    logic wasTempSens;
    logic countEdge;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmpMeta <= 1'b0;
            cmpSync <= 1'b0;
            cmpPrev <= 1'b0;
        end else begin
            cmpMeta <= cmp;
            cmpSync <= cmpMeta;
            cmpPrev <= cmpSync;
        end
    end

    assign inTempSens = phase == tempSensPkg::TEMPSENS;

    // Rising edge, still high one clock later, outside the holdoff
    assign countEdge = inTempSens && cmpSync && !cmpPrev && cmpMeta && holdoff == 2'd0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            holdoff <= 2'd0;
            tsChop <= 1'b0;
            wasTempSens <= 1'b0;
            tmpCount1 <= '0;
            tmpCount2 <= '0;
        end else begin
            wasTempSens <= inTempSens;
            if (countEdge) begin
                holdoff <= 2'd2;
                tsChop <= ~tsChop;
            end else if (holdoff != 2'd0) begin
                holdoff <= holdoff - 2'd1;
            end
            if (inTempSens && !wasTempSens) begin
                tmpCount1 <= '0;
                tmpCount2 <= '0;
            end else if (countEdge && ptatPolarity) begin
                tmpCount1 <= tmpCount1 + 1'b1;
            end else if (countEdge) begin
                tmpCount2 <= tmpCount2 + 1'b1;
            end
        end
    end

    assign cmpP1 = inTempSens ? tsChop : chopPhase;
    assign cmpP2 = ~cmpP1;

endmodule

`default_nettype wire

// File: diodeStepper.sv
`timescale 1ns/100ps
`default_nettype none

module diodeStepper (
    input  logic                clk,
    input  logic                reset,
    input  tempSensPkg::phase_t phase,
    input  logic                cmpSync,
    output logic                pi1,
    output logic                pi2,
    output logic                pii1,
    output logic                pii2,
    output logic                srcN,
    output logic                snk,
    output logic                chopDone,
    output logic                chopPhase
);

    tempSensPkg::step_t step;
    logic [4:0] stepCount;
    logic [4:0] stepLen;
    logic active;
    logic stepLast;
    logic bigOn;
    logic diodeOn;

    assign active = (phase == tempSensPkg::BANDGAP) || (phase == tempSensPkg::PTAT);

    // Clocks spent in the current step
    always_comb begin
        case (step)
            tempSensPkg::BIGDIODE: begin
                stepLen = 5'(tempSensPkg::bigDiodeCycles);
            end
            tempSensPkg::DIODE: begin
                if (phase == tempSensPkg::PTAT)
                    stepLen = 5'(tempSensPkg::ptatDiodeCycles);
                else
                    stepLen = 5'(tempSensPkg::bgDiodeCycles);
            end
            default: begin
                stepLen = 5'd1;
            end
        endcase
    end

    assign stepLast = stepCount == stepLen - 5'd1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step <= tempSensPkg::BLANKBIG;
            stepCount <= '0;
        end else if (!active) begin
            // Parked so each measuring phase starts with a blank
            step <= tempSensPkg::BLANKBIG;
            stepCount <= '0;
        end else if (stepLast) begin
            stepCount <= '0;
            case (step)
                tempSensPkg::BLANKBIG:   step <= tempSensPkg::BIGDIODE;
                tempSensPkg::BIGDIODE:   step <= tempSensPkg::BLANKSMALL;
                tempSensPkg::BLANKSMALL: step <= tempSensPkg::DIODE;
                default:                 step <= tempSensPkg::BLANKBIG;
            endcase
        end else begin
            stepCount <= stepCount + 5'd1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            chopPhase <= 1'b0;
        else if (chopDone)
            chopPhase <= ~chopPhase;
    end

    assign bigOn = active && step == tempSensPkg::BIGDIODE;
    assign diodeOn = active && step == tempSensPkg::DIODE;

    assign chopDone = diodeOn && stepLast;

    assign pi1 = bigOn;
    assign pi2 = bigOn;
    assign pii1 = diodeOn;
    assign pii2 = diodeOn;

    // Current direction set by the comparator
    assign srcN = bigOn && cmpSync;
    assign snk = bigOn && !cmpSync;

endmodule

`default_nettype wire

// File: phaseSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module phaseSequencer #(
    parameter int prechargeCycles = 16,
    parameter int bandgapChops = 16,
    parameter int ptatMinChops = 5,
    parameter int tempSensCycles = 201,
    parameter int sleepCycles = 32
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                chopDone,
    input  logic                cmpSync,
    output tempSensPkg::phase_t phase,
    output logic                ptatPolarity,
    output logic                sBg2Cmp,
    output logic                sBgCtrl,
    output logic                sPtatCtrl,
    output logic                sCap2Cmp,
    output logic                sRef2Cmp,
    output logic                sCapRst,
    output logic                sPtatOut,
    output logic                sRdisconN,
    output logic                pwrUp,
    output logic                preChrg
);

    tempSensPkg::phase_t nextPhase;
    logic [tempSensPkg::timerWidth-1:0] timer;
    logic [tempSensPkg::timerWidth-1:0] chopCount;
    logic prevChopCmp;

    always_comb begin
        nextPhase = phase;
        case (phase)
            // The first cycle after reset only loads the switch pattern
            tempSensPkg::PRECHARGE: begin
                if (timer == tempSensPkg::timerWidth'(prechargeCycles))
                    nextPhase = tempSensPkg::BANDGAP;
            end
            tempSensPkg::BANDGAP: begin
                if (chopDone && chopCount == tempSensPkg::timerWidth'(bandgapChops - 1))
                    nextPhase = tempSensPkg::PTAT;
            end
            tempSensPkg::PTAT: begin
                // Leave once the comparator flips between chops
                if (chopDone && chopCount >= tempSensPkg::timerWidth'(ptatMinChops - 1) &&
                        cmpSync != prevChopCmp)
                    nextPhase = tempSensPkg::TEMPSENS;
            end
            tempSensPkg::TEMPSENS: begin
                if (timer == tempSensPkg::timerWidth'(tempSensCycles - 1))
                    nextPhase = tempSensPkg::SLEEP;
            end
            tempSensPkg::SLEEP: begin
                if (timer == tempSensPkg::timerWidth'(sleepCycles - 1))
                    nextPhase = tempSensPkg::BANDGAP;
            end
            default: nextPhase = tempSensPkg::PRECHARGE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= tempSensPkg::PRECHARGE;
            timer <= '0;
            chopCount <= '0;
            prevChopCmp <= 1'b0;
            ptatPolarity <= 1'b0;
        end else begin
            phase <= nextPhase;
            if (nextPhase != phase) begin
                timer <= '0;
                chopCount <= '0;
            end else begin
                timer <= timer + 1'b1;
                if (chopDone && chopCount != '1)
                    chopCount <= chopCount + 1'b1;
            end
            if (phase == tempSensPkg::PTAT && nextPhase == tempSensPkg::TEMPSENS)
                ptatPolarity <= cmpSync;
            // Comparator at previous chop, zero on PTAT entry
            if (phase != tempSensPkg::PTAT)
                prevChopCmp <= 1'b0;
            else if (chopDone)
                prevChopCmp <= cmpSync;
        end
    end

    // Switch pattern follows the phase being entered
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {sBg2Cmp, sBgCtrl, sPtatCtrl, sCap2Cmp, sRef2Cmp} <= '0;
            {sCapRst, sPtatOut, sRdisconN, pwrUp, preChrg} <= '0;
        end else begin
            sBg2Cmp <= nextPhase inside {tempSensPkg::BANDGAP, tempSensPkg::PTAT};
            sBgCtrl <= nextPhase inside {tempSensPkg::PRECHARGE, tempSensPkg::BANDGAP};
            sPtatCtrl <= nextPhase inside {tempSensPkg::PRECHARGE, tempSensPkg::PTAT,
                                           tempSensPkg::TEMPSENS};
            sCap2Cmp <= nextPhase == tempSensPkg::TEMPSENS;
            sRef2Cmp <= nextPhase == tempSensPkg::TEMPSENS;
            sPtatOut <= nextPhase == tempSensPkg::TEMPSENS;
            sCapRst <= nextPhase inside {tempSensPkg::PRECHARGE, tempSensPkg::SLEEP};
            sRdisconN <= nextPhase inside {tempSensPkg::PRECHARGE, tempSensPkg::BANDGAP,
                                           tempSensPkg::SLEEP};
            pwrUp <= nextPhase != tempSensPkg::SLEEP;
            preChrg <= nextPhase == tempSensPkg::PRECHARGE;
        end
    end

endmodule

`default_nettype wire

// File: tempSensPkg.sv
`default_nettype none

package tempSensPkg;

    // Controller phases
    typedef enum logic [2:0] {
        PRECHARGE,
        BANDGAP,
        PTAT,
        TEMPSENS,
        SLEEP
    } phase_t;

    // Steps of one chopped diode cycle
    typedef enum logic [2:0] {
        BLANKBIG,
        BIGDIODE,
        BLANKSMALL,
        DIODE
    } step_t;

    // Big diode step length in clocks
    localparam int bigDiodeCycles = 6;

    // Small diode step length, per phase
    localparam int bgDiodeCycles = 8;
    localparam int ptatDiodeCycles = 16;

    // Phase timer and chop counter width
    localparam int timerWidth = 8;

endpackage

`default_nettype wire

// File: tempSensTb.sv
`timescale 1ns/100ps
`default_nettype none

module tempSensTb;

    localparam int clkPeriod = 40;
    localparam int watchdogCycles = 6000;
    localparam int countWidth = 8;
    localparam int prechargeCycles = 16;
    localparam int bandgapChops = 16;
    localparam int ptatMinChops = 5;

    logic clk;
    logic reset;
    logic cmp;
    logic pi1, pi2, pii1, pii2, srcN, snk, cmpP1, cmpP2;
    logic sBg2Cmp, sBgCtrl, sPtatCtrl, sCap2Cmp, sRef2Cmp;
    logic sCapRst, sPtatOut, sRdisconN, pwrUp, preChrg;
    logic [countWidth-1:0] tmpCount1;
    logic [countWidth-1:0] tmpCount2;
    logic [31:0] rngState;
    logic polarity;

    tempSensTop DUT (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic reportMismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "Stopped on the first mismatch");
    endtask

    task automatic checkPrecharge();
        int highCycles;
        highCycles = 0;
        @(negedge clk);
        assert ({pi1, pi2, pii1, pii2, srcN, snk} == '0 && {sBg2Cmp, sBgCtrl, sPtatCtrl,
                sCap2Cmp, sRef2Cmp, sCapRst, sPtatOut, sRdisconN, pwrUp, preChrg} == '0)
            else reportMismatch("control outputs not low right after reset");
        while (!preChrg)
            @(negedge clk);
        while (preChrg) begin
            highCycles++;
            @(negedge clk);
        end
        assert (highCycles == prechargeCycles)
            else reportMismatch($sformatf("preChrg high for %0d cycles", highCycles));
        assert (sBg2Cmp && sBgCtrl)
            else reportMismatch("BANDGAP switches not set when preChrg fell");
    endtask

    // Counts diode runs over one sBgCtrl window
    task automatic checkBandgap();
        int runs;
        logic pii2Prev;
        runs = 0;
        pii2Prev = 1'b0;
        while (!sBgCtrl)
            @(negedge clk);
        while (sBgCtrl) begin
            if (pii2 && !pii2Prev)
                runs++;
            pii2Prev = pii2;
            @(negedge clk);
        end
        assert (runs == bandgapChops)
            else reportMismatch($sformatf("%0d pii2 runs in BANDGAP", runs));
    endtask

    // One random cmp level per chop, exit predicted from the level history
    task automatic runPtat(output logic pol);
        int chop;
        logic level;
        logic prevLevel;
        logic exitSeen;
        chop = 0;
        prevLevel = 1'b0;
        exitSeen = 1'b0;
        while (!exitSeen) begin
            chop++;
            rngState = xorshift(rngState);
            level = rngState[7];
            @(posedge clk);
            cmp <= level;
            while (!pii2)
                @(negedge clk);
            while (pii2)
                @(negedge clk);
            if (chop >= ptatMinChops && level != prevLevel) begin
                exitSeen = 1'b1;
                assert (sPtatOut)
                    else reportMismatch($sformatf("no PTAT exit after chop %0d", chop));
            end else begin
                assert (!sPtatOut)
                    else reportMismatch($sformatf("early PTAT exit after chop %0d", chop));
            end
            prevLevel = level;
        end
        pol = level;
    endtask

    task automatic runTempSens(input logic pol);
        int pulses;
        int i;
        rngState = xorshift(rngState);
        pulses = int'(rngState % 32'd20) + 1;
        @(posedge clk);
        cmp <= 1'b0;
        repeat (4) @(posedge clk);
        for (i = 1; i <= pulses; i++) begin
            cmp <= 1'b1;
            repeat (4) @(posedge clk);
            // Last pulse stays high when the polarity is 1
            if (i < pulses || !pol) begin
                cmp <= 1'b0;
                repeat (4) @(posedge clk);
            end
        end
        @(negedge clk);
        assert (sCap2Cmp)
            else reportMismatch("TEMPSENS ended before the pulse train");
        while (sCap2Cmp)
            @(negedge clk);
        assert (sCapRst && !pwrUp)
            else reportMismatch("SLEEP pattern missing after TEMPSENS");
        if (pol) begin
            assert (tmpCount1 == countWidth'(pulses) && tmpCount2 == '0)
                else reportMismatch($sformatf("counts %0d/%0d, expected %0d/0",
                                              tmpCount1, tmpCount2, pulses));
        end else begin
            assert (tmpCount2 == countWidth'(pulses) && tmpCount1 == '0)
                else reportMismatch($sformatf("counts %0d/%0d, expected 0/%0d",
                                              tmpCount1, tmpCount2, pulses));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Watchdog expired before two TEMPSENS rounds completed");
        $display("TEST FAILED");
        $fatal(1, "Run timed out");
    end

    initial begin
        wait (DUT.chk.failCount != 0);
        $display("A bound assertion on the DUT failed at %0t ns", $time);
        $display("TEST FAILED");
        $fatal(1, "Checker assertion failed");
    end

    initial begin
        cmp = 1'b0;
        reset = 1'b1;
        rngState = 32'hf10ab35f;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        checkPrecharge();
        repeat (2) begin
            checkBandgap();
            runPtat(polarity);
            runTempSens(polarity);
        end
        if (DUT.chk.failCount == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "Checker assertions reported failures");
        end
    end

endmodule

`default_nettype wire

// File: tempSensTop.sv
`timescale 1ns/100ps
`default_nettype none

module tempSensTop #(
    parameter int countWidth = 8,
    parameter int prechargeCycles = 16,
    parameter int bandgapChops = 16,
    parameter int ptatMinChops = 5,
    parameter int tempSensCycles = 201,
    parameter int sleepCycles = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmp,
    output logic                  pi1,
    output logic                  pi2,
    output logic                  pii1,
    output logic                  pii2,
    output logic                  srcN,
    output logic                  snk,
    output logic                  cmpP1,
    output logic                  cmpP2,
    output logic                  sBg2Cmp,
    output logic                  sBgCtrl,
    output logic                  sPtatCtrl,
    output logic                  sCap2Cmp,
    output logic                  sRef2Cmp,
    output logic                  sCapRst,
    output logic                  sPtatOut,
    output logic                  sRdisconN,
    output logic                  pwrUp,
    output logic                  preChrg,
    output logic [countWidth-1:0] tmpCount1,
    output logic [countWidth-1:0] tmpCount2
);

    tempSensPkg::phase_t phase;
    logic chopDone;
    logic chopPhase;
    logic cmpSync;
    logic ptatPolarity;

    phaseSequencer #(
        .prechargeCycles(prechargeCycles),
        .bandgapChops   (bandgapChops),
        .ptatMinChops   (ptatMinChops),
        .tempSensCycles (tempSensCycles),
        .sleepCycles    (sleepCycles)
    ) sequencer (
        .clk         (clk),
        .reset       (reset),
        .chopDone    (chopDone),
        .cmpSync     (cmpSync),
        .phase       (phase),
        .ptatPolarity(ptatPolarity),
        .sBg2Cmp     (sBg2Cmp),
        .sBgCtrl     (sBgCtrl),
        .sPtatCtrl   (sPtatCtrl),
        .sCap2Cmp    (sCap2Cmp),
        .sRef2Cmp    (sRef2Cmp),
        .sCapRst     (sCapRst),
        .sPtatOut    (sPtatOut),
        .sRdisconN   (sRdisconN),
        .pwrUp       (pwrUp),
        .preChrg     (preChrg)
    );

    diodeStepper stepper (
        .clk      (clk),
        .reset    (reset),
        .phase    (phase),
        .cmpSync  (cmpSync),
        .pi1      (pi1),
        .pi2      (pi2),
        .pii1     (pii1),
        .pii2     (pii2),
        .srcN     (srcN),
        .snk      (snk),
        .chopDone (chopDone),
        .chopPhase(chopPhase)
    );

    cmpFrontEnd #(
        .countWidth(countWidth)
    ) frontEnd (
        .clk         (clk),
        .reset       (reset),
        .cmp         (cmp),
        .phase       (phase),
        .ptatPolarity(ptatPolarity),
        .chopPhase   (chopPhase),
        .cmpSync     (cmpSync),
        .cmpP1       (cmpP1),
        .cmpP2       (cmpP2),
        .tmpCount1   (tmpCount1),
        .tmpCount2   (tmpCount2)
    );

endmodule

`default_nettype wire

// File: tempSens_chk.sv
`timescale 1ns/100ps
`default_nettype none

module tempSensChk (
    input logic clk,
    input logic reset,
    input logic pi1,
    input logic pi2,
    input logic pii1,
    input logic pii2,
    input logic srcN,
    input logic snk,
    input logic cmpP1,
    input logic cmpP2,
    input logic sBg2Cmp,
    input logic sBgCtrl,
    input logic sPtatCtrl,
    input logic sCap2Cmp,
    input logic sRef2Cmp,
    input logic sCapRst,
    input logic sPtatOut,
    input logic sRdisconN,
    input logic pwrUp,
    input logic preChrg
);

    int failCount = 0;
    logic inBandgap;

    assign inBandgap = sBgCtrl && sBg2Cmp;

    // Phase switch patterns
    ptatOutSwitches: assert property (@(posedge clk) disable iff (reset)
        sPtatOut |-> sCap2Cmp && sRef2Cmp && sPtatCtrl)
        else begin
            failCount++;
            $error("sPtatOut high without sCap2Cmp, sRef2Cmp and sPtatCtrl");
        end

    prechargeApart: assert property (@(posedge clk) disable iff (reset)
        !(preChrg && sBg2Cmp))
        else begin
            failCount++;
            $error("preChrg overlaps sBg2Cmp");
        end

    // Powered down only in the SLEEP pattern
    pwrUpPattern: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> (!pwrUp == (sCapRst && sRdisconN && !sBgCtrl)))
        else begin
            failCount++;
            $error("pwrUp does not match the SLEEP switch pattern");
        end

    diodeApart: assert property (@(posedge clk) disable iff (reset)
        !(pi2 && pii2))
        else begin
            failCount++;
            $error("pi2 and pii2 high together");
        end

    // Both switches of a diode pair move together
    diodePairs: assert property (@(posedge clk) disable iff (reset)
        pi1 == pi2 && pii1 == pii2)
        else begin
            failCount++;
            $error("pi1 or pii1 differs from its pair");
        end

    sourceApart: assert property (@(posedge clk) disable iff (reset)
        !(srcN && snk))
        else begin
            failCount++;
            $error("srcN and snk high together");
        end

    // One current direction during each big diode step, none otherwise
    sourceDuringBig: assert property (@(posedge clk) disable iff (reset)
        (srcN || snk) == pi2)
        else begin
            failCount++;
            $error("current source state does not follow the big diode step");
        end

    bigDiodeRun: assert property (@(posedge clk) disable iff (reset)
        $rose(pi2) |-> pi2[*tempSensPkg::bigDiodeCycles] ##1 (!pi2 && !pii2))
        else begin
            failCount++;
            $error("pi2 run length or following blank is wrong");
        end

    // One chop toggle per diode run
    bandgapChop: assert property (@(posedge clk) disable iff (reset)
        inBandgap |-> ($fell(pii2) == $changed(cmpP1)))
        else begin
            failCount++;
            $error("cmpP1 toggle not aligned with the end of a pii2 run");
        end

    cmpComplement: assert property (@(posedge clk) disable iff (reset)
        cmpP2 == !cmpP1)
        else begin
            failCount++;
            $error("cmpP2 is not the inverse of cmpP1");
        end

endmodule

bind tempSensTop tempSensChk chk (.*);

`default_nettype wire

// File: vlog.f
tempSensPkg.sv
phaseSequencer.sv
diodeStepper.sv
cmpFrontEnd.sv
tempSensTop.sv
tempSens_chk.sv
tempSensTb.sv
